//--- dv/hssi_emul_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hssi_emul_config.svh"

module hssi_emul_tb
    import hssi_emul_pkg::*;
();

    localparam int DEPTH       = `HSSI_FIFO_DEPTH;
    localparam int ACK_LIMIT   = 16;
    localparam int STALL_LIMIT = 4 * DEPTH + 16;
    localparam int DRAIN_LIMIT = 4 * DEPTH + 16;

    // Kinds of table step
    typedef enum logic [1:0] {
        STEP_WRITE,
        STEP_READ,
        STEP_SEND,
        STEP_DRAIN
    } step_kind_e;

    // value is write data, expected read data, beat count or CTRL release value
    typedef struct packed {
        step_kind_e           kind;
        reg_addr_e            addr;
        logic [`WB_DAT_W-1:0] value;
    } step_t;

    // ========================================
    // DUT and clock
    // ========================================

    logic       hssi_clk_pll;
    logic       arst_n;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       tx_valid;
    hssi_beat_t tx_beat;
    logic       tx_ready;
    logic       rx_valid;
    hssi_beat_t rx_beat;

    hssi_emul_top dut_i (
        .i_hssi_clk_pll (hssi_clk_pll),
        .i_arst_n       (arst_n),
        .i_wb           (wb_req),
        .o_wb           (wb_rsp),
        .i_tx_valid     (tx_valid),
        .i_tx           (tx_beat),
        .o_tx_ready     (tx_ready),
        .o_rx_valid     (rx_valid),
        .o_rx           (rx_beat)
    );

    initial
    begin
        hssi_clk_pll = 1'b0;
        forever #4 hssi_clk_pll = ~hssi_clk_pll;
    end

    // Reference model state
    integer               seed = 32'h854;
    hssi_beat_t           exp_q[$];
    logic                 model_en;
    logic                 model_pause;
    logic [`WB_DAT_W-1:0] exp_tx_frames;
    logic [`WB_DAT_W-1:0] exp_rx_frames;
    int                   rx_count;
    // Stimulus table
    step_t                step_q[$];
    string                step_name_q[$];
    logic                 table_ready;

    // ========================================
    // Failure handling and compares
    // ========================================

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [`WB_DAT_W-1:0] exp,
                              input logic [`WB_DAT_W-1:0] act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_beat(input string name, input hssi_beat_t exp, input hssi_beat_t act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    // ========================================
    // Bus and stream drivers
    // ========================================

    // Classic cycle entered and left just after a falling edge
    task automatic wb_access(input logic we, input reg_addr_e addr,
                             input logic [`WB_DAT_W-1:0] wdata,
                             output logic [`WB_DAT_W-1:0] rdata);
        int waited;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = addr;
        wb_req.dat = wdata;
        waited     = 0;
        @(negedge hssi_clk_pll);
        while (wb_rsp.ack !== 1'b1)
        begin
            if (waited >= ACK_LIMIT)
            begin
                $display("ERROR: Wishbone ack never arrived for address %0d", addr);
                stop_run();
            end
            waited++;
            @(negedge hssi_clk_pll);
        end
        rdata  = wb_rsp.dat;
        wb_req = '0;
        // Ack must last exactly one cycle
        @(negedge hssi_clk_pll);
        if (wb_rsp.ack !== 1'b0)
        begin
            $display("ERROR: Wishbone ack stayed high for more than one cycle");
            stop_run();
        end
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [`WB_DAT_W-1:0] value);
        logic [`WB_DAT_W-1:0] unused;
        wb_access(1'b1, addr, value, unused);
        // Control bits already active on the ack edge
        if (addr == REG_CTRL)
        begin
            model_en    = value[0];
            model_pause = value[1];
        end
    endtask

    task automatic reg_read(input string name, input reg_addr_e addr,
                            input logic [`WB_DAT_W-1:0] exp);
        logic [`WB_DAT_W-1:0] rdata;
        wb_access(1'b0, addr, '0, rdata);
        check_word(name, exp, rdata);
    endtask

    // A frame's final beat enables 1 to KEEP_W bytes
    function automatic logic [`HSSI_KEEP_W-1:0] tail_keep();
        int unsigned shift;
        shift = {$random(seed)} % `HSSI_KEEP_W;
        return {`HSSI_KEEP_W{1'b1}} >> shift;
    endfunction

    // While paused the buffer fills and RX stays silent
    task automatic check_backpressure(input string name);
        check_word({name, " tx_ready"}, `WB_DAT_W'(exp_q.size() < DEPTH), `WB_DAT_W'(tx_ready));
        check_word({name, " rx_valid"}, '0, `WB_DAT_W'(rx_valid));
    endtask

    task automatic send_frame(input string name, input int beats);
        hssi_beat_t beat;
        int         stall;
        for (int i = 0; i < beats; i++)
        begin
            for (int w = 0; w < `HSSI_DATA_W / 32; w++)
            begin
                beat.data[w*32 +: 32] = $random(seed);
            end
            beat.last = (i == beats - 1);
            beat.keep = beat.last ? tail_keep() : {`HSSI_KEEP_W{1'b1}};
            tx_valid  = 1'b1;
            tx_beat   = beat;
            if (model_en && model_pause)
            begin
                check_backpressure($sformatf("%s beat %0d", name, i));
            end
            // Ready comes from registered state and is stable at the falling edge
            stall = 0;
            while (tx_ready !== 1'b1)
            begin
                if (stall >= STALL_LIMIT)
                begin
                    $display("ERROR: TX ready stayed low in %s", name);
                    stop_run();
                end
                stall++;
                @(negedge hssi_clk_pll);
            end
            // Transfer happens on the coming rising edge
            if (model_en)
            begin
                exp_q.push_back(beat);
                if (beat.last)
                begin
                    exp_rx_frames = exp_rx_frames + 1;
                end
            end
            if (beat.last)
            begin
                exp_tx_frames = exp_tx_frames + 1;
            end
            @(negedge hssi_clk_pll);
        end
        tx_valid = 1'b0;
        tx_beat  = '0;
    endtask

    // Release pause, wait for the model queue to empty, then compare counters
    task automatic release_drain(input string name, input logic [`WB_DAT_W-1:0] ctrl);
        int waited;
        if (model_en && model_pause)
        begin
            check_backpressure({name, " before release"});
        end
        reg_write(REG_CTRL, ctrl);
        waited = 0;
        while (exp_q.size() != 0)
        begin
            if (waited >= DRAIN_LIMIT)
            begin
                $display("ERROR: %0d beats never came out on RX in %s", exp_q.size(), name);
                stop_run();
            end
            waited++;
            @(negedge hssi_clk_pll);
        end
        // Let the RX frame counter take the final last beat
        repeat (2) @(negedge hssi_clk_pll);
        reg_read({name, " tx frames"}, REG_TX_FRAMES, exp_tx_frames);
        reg_read({name, " rx frames"}, REG_RX_FRAMES, exp_rx_frames);
    endtask

    // ========================================
    // RX monitor and watchdog
    // ========================================

    always @(negedge hssi_clk_pll)
    begin : rx_monitor
        hssi_beat_t exp_beat;
        if (rx_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("ERROR: RX beat %h arrived with nothing outstanding", rx_beat);
                stop_run();
            end
            else
            begin
                exp_beat = exp_q.pop_front();
                check_beat($sformatf("rx beat %0d", rx_count), exp_beat, rx_beat);
                rx_count++;
            end
        end
    end

    initial
    begin : watchdog
        int limit;
        wait (table_ready === 1'b1);
        limit = step_q.size() * 200;
        repeat (limit) @(posedge hssi_clk_pll);
        $display("ERROR: watchdog expired after %0d cycles, test did not finish", limit);
        stop_run();
    end

    // ========================================
    // Stimulus table and main sequence
    // ========================================

    task automatic add_step(input step_kind_e kind, input reg_addr_e addr,
                            input logic [`WB_DAT_W-1:0] value, input string name);
        step_t step;
        step.kind  = kind;
        step.addr  = addr;
        step.value = value;
        step_q.push_back(step);
        step_name_q.push_back(name);
    endtask

    task automatic build_table();
        // Reset values
        add_step(STEP_READ,  REG_CTRL,      32'd0, "reset ctrl");
        add_step(STEP_READ,  REG_STATUS,    32'd0, "reset status");
        add_step(STEP_READ,  REG_TX_FRAMES, 32'd0, "reset tx frames");
        add_step(STEP_READ,  REG_RX_FRAMES, 32'd0, "reset rx frames");
        // Plain loopback with frames of 1 to 5 beats
        add_step(STEP_WRITE, REG_CTRL,      32'd1, "enable");
        for (int n = 1; n <= 5; n++)
        begin
            add_step(STEP_SEND, REG_CTRL, n, $sformatf("loop frame %0d", n));
        end
        add_step(STEP_DRAIN, REG_CTRL,      32'd1, "loop drain");
        // Pause fills the buffer with exactly DEPTH beats
        add_step(STEP_WRITE, REG_CTRL,      32'd3, "pause on");
        add_step(STEP_READ,  REG_CTRL,      32'd3, "ctrl readback");
        add_step(STEP_SEND,  REG_CTRL,      DEPTH / 2, "paused frame a");
        add_step(STEP_SEND,  REG_CTRL,      DEPTH - DEPTH / 2, "paused frame b");
        add_step(STEP_DRAIN, REG_CTRL,      32'd1, "pause release");
        // Everything is dropped with emulation off
        add_step(STEP_WRITE, REG_CTRL,      32'd0, "disable");
        add_step(STEP_SEND,  REG_CTRL,      32'd2, "drop frame a");
        add_step(STEP_SEND,  REG_CTRL,      32'd3, "drop frame b");
        add_step(STEP_READ,  REG_STATUS,    32'd1, "drop flag set");
        add_step(STEP_WRITE, REG_STATUS,    32'd1, "drop flag clear");
        add_step(STEP_READ,  REG_STATUS,    32'd0, "drop flag cleared");
        add_step(STEP_DRAIN, REG_CTRL,      32'd0, "final counters");
    endtask

    initial
    begin
        string name;
        arst_n        = 1'b0;
        wb_req        = '0;
        tx_valid      = 1'b0;
        tx_beat       = '0;
        model_en      = 1'b0;
        model_pause   = 1'b0;
        exp_tx_frames = '0;
        exp_rx_frames = '0;
        rx_count      = 0;
        table_ready   = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (4) @(posedge hssi_clk_pll);
        @(negedge hssi_clk_pll);
        arst_n = 1'b1;
        @(negedge hssi_clk_pll);
        // Tied ready and silent RX out of reset
        check_word("reset tx_ready", `WB_DAT_W'(1), `WB_DAT_W'(tx_ready));
        check_word("reset rx_valid", '0, `WB_DAT_W'(rx_valid));

        for (int s = 0; s < step_q.size(); s++)
        begin
            name = $sformatf("step %0d (%s)", s, step_name_q[s]);
            case (step_q[s].kind)
                STEP_WRITE: reg_write(step_q[s].addr, step_q[s].value);
                STEP_READ:  reg_read(name, step_q[s].addr, step_q[s].value);
                STEP_SEND:  send_frame(name, int'(step_q[s].value));
                default:    release_drain(name, step_q[s].value);
            endcase
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the HSSI emulation testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module hssi_emul_tb \
    -f src.f -o hssi_emul_sim

# Simulator exits non-zero on a fatal check
out=$(./obj_dir/hssi_emul_sim 2>&1) || { echo "$out"; exit 1; }
echo "$out"

# Pass only when the testbench reported it
echo "$out" | grep -q "TEST RESULT: PASS"

//--- src.f
+incdir+verilog
verilog/hssi_emul_pkg.sv
verilog/hssi_reg_ctrl.sv
verilog/hssi_tx_gate.sv
verilog/hssi_loop_fifo.sv
verilog/hssi_emul_top.sv
dv/hssi_emul_tb.sv

//--- verilog/hssi_emul_config.svh
`ifndef HSSI_EMUL_CONFIG_SVH
`define HSSI_EMUL_CONFIG_SVH

// ========================================
// Stream beat geometry
// ========================================

// Payload width of one Ethernet beat
`define HSSI_DATA_W 64
// One byte enable per data byte
`define HSSI_KEEP_W (`HSSI_DATA_W / 8)

// Loopback buffer entries, any power of two
`define HSSI_FIFO_DEPTH 8

// ========================================
// Wishbone register port
// ========================================

// Word address, four registers
`define WB_ADR_W 2
`define WB_DAT_W 32

`endif

//--- verilog/hssi_emul_pkg.sv
`default_nettype none

`include "hssi_emul_config.svh"

package hssi_emul_pkg;

    // ========================================
    // Stream types
    // ========================================

    // One Ethernet beat, valid and ready travel beside it
    typedef struct packed {
        logic [`HSSI_DATA_W-1:0] data;
        logic [`HSSI_KEEP_W-1:0] keep;
        // Final beat of a frame
        logic                    last;
    } hssi_beat_t;

    // ========================================
    // Wishbone types
    // ========================================

    // Master side of a classic cycle
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`WB_ADR_W-1:0] adr;
        logic [`WB_DAT_W-1:0] dat;
    } wb_req_t;

    // Slave side, dat only meaningful with ack
    typedef struct packed {
        logic                 ack;
        logic [`WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // Word addresses of the register file
    typedef enum logic [`WB_ADR_W-1:0] {
        REG_CTRL      = 2'd0,
        REG_STATUS    = 2'd1,
        REG_TX_FRAMES = 2'd2,
        REG_RX_FRAMES = 2'd3
    } reg_addr_e;

    // Bus FSM of the register block
    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

endpackage

`default_nettype wire

//--- verilog/hssi_emul_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hssi_emul_config.svh"

module hssi_emul_top
    import hssi_emul_pkg::*;
(
    input  wire logic       i_hssi_clk_pll,
    input  wire logic       i_arst_n,

    // Register port
    input  wire wb_req_t    i_wb,
    output wb_rsp_t         o_wb,

    // User TX stream
    input  wire logic       i_tx_valid,
    input  wire hssi_beat_t i_tx,
    output logic            o_tx_ready,

    // Looped back RX stream
    output logic            o_rx_valid,
    output hssi_beat_t      o_rx
);

    // ========================================
    // Internal wiring
    // ========================================

    logic                 emul_en;
    logic                 pause;
    logic                 drop_clr;
    logic                 drop_flag;
    logic [`WB_DAT_W-1:0] tx_frames;
    logic [`WB_DAT_W-1:0] rx_frames;
    // TX gate to buffer
    logic                 push;
    hssi_beat_t           push_beat;
    logic                 fifo_full;

    hssi_reg_ctrl reg_ctrl_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_arst_n       (i_arst_n),
        .i_wb           (i_wb),
        .o_wb           (o_wb),
        .o_emul_en      (emul_en),
        .o_pause        (pause),
        .o_drop_clr     (drop_clr),
        .i_drop_flag    (drop_flag),
        .i_tx_frames    (tx_frames),
        .i_rx_frames    (rx_frames)
    );

    hssi_tx_gate tx_gate_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_arst_n       (i_arst_n),
        .i_emul_en      (emul_en),
        .i_tx_valid     (i_tx_valid),
        .i_tx           (i_tx),
        .o_tx_ready     (o_tx_ready),
        .i_fifo_full    (fifo_full),
        .o_push         (push),
        .o_push_beat    (push_beat),
        .i_drop_clr     (drop_clr),
        .o_drop_flag    (drop_flag),
        .o_tx_frames    (tx_frames)
    );

    hssi_loop_fifo loop_fifo_i (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_arst_n       (i_arst_n),
        .i_push         (push),
        .i_push_beat    (push_beat),
        .o_full         (fifo_full),
        .i_pause        (pause),
        .o_rx_valid     (o_rx_valid),
        .o_rx           (o_rx),
        .o_rx_frames    (rx_frames)
    );

endmodule

`default_nettype wire

//--- verilog/hssi_loop_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "hssi_emul_config.svh"

module hssi_loop_fifo
    import hssi_emul_pkg::*;
(
    input  wire logic                 i_hssi_clk_pll,
    input  wire logic                 i_arst_n,

    // Write side from the TX gate
    input  wire logic                 i_push,
    input  wire hssi_beat_t           i_push_beat,
    output logic                      o_full,

    // Flow control pause and RX stream
    input  wire logic                 i_pause,
    output logic                      o_rx_valid,
    output hssi_beat_t                o_rx,
    output logic [`WB_DAT_W-1:0]      o_rx_frames
);

    localparam int DEPTH = `HSSI_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    // Total occupancy, buffer plus output stage, that stalls TX
    localparam logic [AW:0] FULL_LEVEL = DEPTH[AW:0];

    // ========================================
    // Storage
    // ========================================

    hssi_beat_t        mem [DEPTH];
    // Extra wrap bit tells empty from full
    logic [AW:0]       wr_ptr_q;
    logic [AW:0]       rd_ptr_q;
    logic [AW:0]       occupancy;
    logic              mem_empty;
    hssi_beat_t        out_q;
    logic              out_valid_q;
    logic              deliver;
    logic              load;

    assign mem_empty = (wr_ptr_q == rd_ptr_q);
    assign occupancy = (wr_ptr_q - rd_ptr_q) + {{AW{1'b0}}, out_valid_q};
    assign o_full    = (occupancy == FULL_LEVEL);

    // No ready on RX, a visible beat is always taken
    assign deliver = out_valid_q && !i_pause;
    // Refill the output stage when it is empty or being emptied
    assign load    = !mem_empty && (!out_valid_q || deliver);

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (i_push)
        begin
            mem[wr_ptr_q[AW-1:0]] <= i_push_beat;
        end
    end

    // ========================================
    // Pointers and output stage
    // ========================================

    always_ff @(posedge i_hssi_clk_pll or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            out_valid_q <= 1'b0;
            o_rx_frames <= '0;
        end
        else
        begin
            if (i_push)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end

            if (load)
            begin
                rd_ptr_q    <= rd_ptr_q + 1'b1;
                out_valid_q <= 1'b1;
            end
            else if (deliver)
            begin
                out_valid_q <= 1'b0;
            end

            // One RX frame per delivered last beat
            if (deliver && out_q.last)
            begin
                o_rx_frames <= o_rx_frames + 1'b1;
            end
        end
    end

    // Beat payload of the output stage
    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (load)
        begin
            out_q <= mem[rd_ptr_q[AW-1:0]];
        end
    end

    // Pause hides the held beat without losing it
    assign o_rx_valid = deliver;
    assign o_rx       = out_q;

endmodule

`default_nettype wire

//--- verilog/hssi_reg_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "hssi_emul_config.svh"

module hssi_reg_ctrl
    import hssi_emul_pkg::*;
(
    input  wire logic                 i_hssi_clk_pll,
    input  wire logic                 i_arst_n,

    // Wishbone classic slave
    input  wire wb_req_t              i_wb,
    output wb_rsp_t                   o_wb,

    // Channel control
    output logic                      o_emul_en,
    output logic                      o_pause,
    output logic                      o_drop_clr,

    // Status and counters from the datapath
    input  wire logic                 i_drop_flag,
    input  wire logic [`WB_DAT_W-1:0] i_tx_frames,
    input  wire logic [`WB_DAT_W-1:0] i_rx_frames
);

    // ========================================
    // Request decode
    // ========================================

    wb_state_e            state_q;
    wb_state_e            state_d;
    reg_addr_e            addr;
    logic                 req;
    logic                 wr;
    logic                 ack;
    logic                 emul_en_q;
    logic                 pause_q;
    logic [`WB_DAT_W-1:0] rdat_d;
    logic [`WB_DAT_W-1:0] rdat_q;

    // New cycle only seen from idle, so a held stb is not served twice
    assign req  = (state_q == WB_IDLE) && i_wb.cyc && i_wb.stb;
    assign wr   = req && i_wb.we;
    assign addr = reg_addr_e'(i_wb.adr);

    // Write-one-to-clear of the drop flag
    // Combinational so the flag clears on the ack edge itself
    assign o_drop_clr = wr && (addr == REG_STATUS) && i_wb.dat[0];

    // ========================================
    // Bus FSM
    // ========================================

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            WB_IDLE:
            begin
                // Accept and answer on the next edge
                if (i_wb.cyc && i_wb.stb)
                begin
                    state_d = WB_ACK;
                end
            end
            WB_ACK:
            begin
                // Single ack cycle, then wait for the next request
                state_d = WB_IDLE;
            end
            default:
            begin
                state_d = WB_IDLE;
            end
        endcase
    end

    // State and control register
    always_ff @(posedge i_hssi_clk_pll or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q   <= WB_IDLE;
            emul_en_q <= 1'b0;
            pause_q   <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            // Write lands on the same edge that raises ack
            if (wr && (addr == REG_CTRL))
            begin
                emul_en_q <= i_wb.dat[0];
                pause_q   <= i_wb.dat[1];
            end
        end
    end

    // ========================================
    // Read path
    // ========================================

    // Register values of the request cycle
    always_comb
    begin
        rdat_d = '0;
        case (addr)
            REG_CTRL:
            begin
                rdat_d[0] = emul_en_q;
                rdat_d[1] = pause_q;
            end
            REG_STATUS:
            begin
                rdat_d[0] = i_drop_flag;
            end
            REG_TX_FRAMES:
            begin
                rdat_d = i_tx_frames;
            end
            REG_RX_FRAMES:
            begin
                rdat_d = i_rx_frames;
            end
            default:
            begin
                rdat_d = '0;
            end
        endcase
    end

    // Captured alongside the state change, presented with ack
    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (req)
        begin
            rdat_q <= rdat_d;
        end
    end

    assign ack = (state_q == WB_ACK);

    // Data bus idles at zero outside the ack cycle
    always_comb
    begin
        o_wb.ack = ack;
        o_wb.dat = ack ? rdat_q : '0;
    end

    assign o_emul_en = emul_en_q;
    assign o_pause   = pause_q;

endmodule

`default_nettype wire

//--- verilog/hssi_tx_gate.sv
`timescale 1ns/1ps
`default_nettype none

`include "hssi_emul_config.svh"

module hssi_tx_gate
    import hssi_emul_pkg::*;
(
    input  wire logic                 i_hssi_clk_pll,
    input  wire logic                 i_arst_n,
    input  wire logic                 i_emul_en,

    // User TX stream
    input  wire logic                 i_tx_valid,
    input  wire hssi_beat_t           i_tx,
    output logic                      o_tx_ready,

    // Write side of the loopback buffer
    input  wire logic                 i_fifo_full,
    output logic                      o_push,
    output hssi_beat_t                o_push_beat,

    // Sticky drop flag and frame count
    input  wire logic                 i_drop_clr,
    output logic                      o_drop_flag,
    output logic [`WB_DAT_W-1:0]      o_tx_frames
);

    // ========================================
    // Handshake
    // ========================================

    logic accept;
    logic drop;

    // With emulation off the channel swallows everything
    // With it on, only a full buffer stalls the user
    assign o_tx_ready = !i_emul_en || !i_fifo_full;
    assign accept     = i_tx_valid && o_tx_ready;

    // Accepted beats go to the buffer or are thrown away
    assign o_push      = accept && i_emul_en;
    assign drop        = accept && !i_emul_en;
    assign o_push_beat = i_tx;

    // ========================================
    // Flag and counter
    // ========================================

    always_ff @(posedge i_hssi_clk_pll or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_drop_flag <= 1'b0;
            o_tx_frames <= '0;
        end
        else
        begin
            // Software clear wins over a drop in the same cycle
            if (i_drop_clr)
            begin
                o_drop_flag <= 1'b0;
            end
            else if (drop)
            begin
                o_drop_flag <= 1'b1;
            end

            // Dropped frames count too
            if (accept && i_tx.last)
            begin
                o_tx_frames <= o_tx_frames + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
